//--- usb_axi_pkg.sv
`default_nettype none

package usb_axi_pkg;

    // widths with a meaning of their own
    typedef logic [7:0]  byte_t;     // one byte on the FT232H bus
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [1:0]  resp_t;
    typedef logic [15:0] xfer_cnt_t;

    localparam int    BYTES_PER_WORD = 4;
    localparam addr_t BASE_ADDR      = 32'h8000_0000;
    localparam addr_t ADDR_STEP      = 32'd4;
    localparam int    FIFO_DEPTH     = 8;
    localparam int    FIFO_PTR_W     = 3;
    localparam resp_t RESP_OKAY      = 2'b00;

    //****************************************
    // AXI4-Lite channel payloads
    //****************************************
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } aw_chan_t;

    typedef struct packed {
        word_t                     data;
        logic [BYTES_PER_WORD-1:0] strb;
    } w_chan_t;

    typedef struct packed {
        resp_t resp;
    } b_chan_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } ar_chan_t;

    typedef struct packed {
        word_t data;
        resp_t resp;
    } r_chan_t;

    // state machines
    typedef enum logic [1:0] {USB_IDLE, USB_READ, USB_WRITE} usb_state_e;
    typedef enum logic [2:0] {WR_IDLE, WR_START, WR_ADDR, WR_DATA, WR_WAIT_B} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_WAIT_R} rd_state_e;

endpackage

`default_nettype wire

//--- word_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module word_fifo (
    input  wire                     sys_clk,
    input  wire                     sys_rst_n,
    input  wire                     push_i,
    input  wire usb_axi_pkg::word_t push_word_i,
    input  wire                     pop_i,
    output usb_axi_pkg::word_t      pop_word_o,
    output logic                    empty_o,
    output logic                    full_o,
    output logic                    nearly_full_o
);

    import usb_axi_pkg::*;

    word_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);    // slot freed this cycle

    always_ff @(posedge sys_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_word_i;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign pop_word_o    = mem[rd_ptr];    // head word with no read latency
    assign empty_o       = (count == '0);
    assign full_o        = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign nearly_full_o = (count >= (FIFO_PTR_W+1)'(FIFO_DEPTH - 1));    // under two free

endmodule

`default_nettype wire

//--- ft_fifo_port.sv
`timescale 1ns/1ns
`default_nettype none

module ft_fifo_port (
    input  wire                     sys_clk,
    input  wire                     sys_rst_n,
    // FT232H bus
    input  wire                     usb_rxf_n_i,
    input  wire                     usb_txe_n_i,
    input  wire usb_axi_pkg::byte_t usb_data_i,
    output logic                    usb_oe_n_o,
    output logic                    usb_rd_n_o,
    output logic                    usb_wr_n_o,
    output usb_axi_pkg::byte_t      usb_data_o,
    output logic                    usb_data_oe_o,
    // inbound word FIFO
    output logic                    in_push_o,
    output usb_axi_pkg::word_t      in_word_o,
    input  wire                     in_nearly_full_i,
    // outbound word FIFO
    output logic                    out_pop_o,
    input  wire usb_axi_pkg::word_t out_word_i,
    input  wire                     out_empty_i
);

    import usb_axi_pkg::*;

    usb_state_e state;
    usb_state_e state_next;
    logic       oe_n_d0;
    logic       rx_take;
    logic       rx_last;
    logic [1:0] rx_cnt;
    word_t      rx_word;
    logic       tx_last;
    logic [1:0] tx_cnt;
    word_t      tx_word;

    //****************************************
    // bus arbiter with read priority
    //****************************************
    always_comb begin
        state_next = state;
        case (state)
            USB_IDLE: begin
                if (!usb_rxf_n_i && !in_nearly_full_i)
                    state_next = USB_READ;
                else if (!usb_txe_n_i && !out_empty_i)
                    state_next = USB_WRITE;
            end
            USB_READ: begin
                if (usb_rxf_n_i || in_nearly_full_i)
                    state_next = USB_IDLE;
            end
            USB_WRITE: begin
                if (tx_last)    // fourth byte went out
                    state_next = USB_IDLE;
            end
            default: state_next = USB_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= USB_IDLE;
            usb_oe_n_o <= 1'b1;
            oe_n_d0    <= 1'b1;
        end else begin
            state      <= state_next;
            // oe low only once settled in READ
            usb_oe_n_o <= !(state == USB_READ && state_next == USB_READ);
            oe_n_d0    <= usb_oe_n_o;
        end
    end

    // rd strobe trails oe by one cycle
    assign usb_rd_n_o = usb_oe_n_o | oe_n_d0;

    //****************************************
    // byte packing, LSB first
    //****************************************
    assign rx_take = !usb_rd_n_o && !usb_rxf_n_i;
    assign rx_last = rx_take && (rx_cnt == 2'(BYTES_PER_WORD - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rx_cnt    <= 2'd0;
            in_push_o <= 1'b0;
        end else begin
            if (rx_take)
                rx_cnt <= rx_cnt + 2'd1;    // wraps after the top byte
            in_push_o <= rx_last;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rx_take)
            rx_word[8*rx_cnt +: 8] <= usb_data_i;
    end

    assign in_word_o = rx_word;

    //****************************************
    // byte unpacking
    //****************************************
    assign out_pop_o     = (state == USB_IDLE) && (state_next == USB_WRITE);
    assign usb_data_oe_o = (state == USB_WRITE);
    assign usb_wr_n_o    = !(state == USB_WRITE && !usb_txe_n_i);    // host may stall
    assign tx_last       = !usb_wr_n_o && (tx_cnt == 2'(BYTES_PER_WORD - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            tx_cnt <= 2'd0;
        else if (out_pop_o)
            tx_cnt <= 2'd0;
        else if (!usb_wr_n_o)
            tx_cnt <= tx_cnt + 2'd1;
    end

    // word stays held until all bytes are out
    always_ff @(posedge sys_clk) begin
        if (out_pop_o)
            tx_word <= out_word_i;
    end

    assign usb_data_o = tx_word[8*tx_cnt +: 8];

endmodule

`default_nettype wire

//--- axi_lite_writer.sv
`timescale 1ns/1ns
`default_nettype none

module axi_lite_writer (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        fifo_empty_i,
    input  wire usb_axi_pkg::word_t    fifo_word_i,
    output logic                       fifo_pop_o,
    output usb_axi_pkg::aw_chan_t      m_aw_o,
    output logic                       m_aw_valid_o,
    input  wire                        m_aw_ready_i,
    output usb_axi_pkg::w_chan_t       m_w_o,
    output logic                       m_w_valid_o,
    input  wire                        m_w_ready_i,
    input  wire usb_axi_pkg::b_chan_t  m_b_i,
    input  wire                        m_b_valid_i,
    output logic                       m_b_ready_o,
    output logic                       wr_done_o
);

    import usb_axi_pkg::*;

    wr_state_e state;
    wr_state_e state_next;
    addr_t     wr_addr;
    word_t     wr_data;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    logic      b_okay;

    assign aw_fire = m_aw_valid_o && m_aw_ready_i;
    assign w_fire  = m_w_valid_o && m_w_ready_i;
    assign b_fire  = m_b_valid_i && m_b_ready_o;
    assign b_okay  = (m_b_i.resp == RESP_OKAY);

    // aw alone pending in WR_ADDR and w alone in WR_DATA
    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE:   if (!fifo_empty_i) state_next = WR_START;
            WR_START: begin
                if (aw_fire && w_fire)
                    state_next = WR_WAIT_B;
                else if (aw_fire)
                    state_next = WR_DATA;
                else if (w_fire)
                    state_next = WR_ADDR;
            end
            WR_ADDR:   if (aw_fire) state_next = WR_WAIT_B;
            WR_DATA:   if (w_fire) state_next = WR_WAIT_B;
            WR_WAIT_B: if (b_fire) state_next = b_okay ? WR_IDLE : WR_START;    // error reissues
            default:   state_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= WR_IDLE;
            wr_addr   <= BASE_ADDR;
            wr_done_o <= 1'b0;
        end else begin
            state     <= state_next;
            wr_done_o <= b_fire && b_okay;
            if (b_fire && b_okay)
                wr_addr <= wr_addr + ADDR_STEP;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fifo_pop_o)
            wr_data <= fifo_word_i;
    end

    assign fifo_pop_o   = (state == WR_IDLE) && !fifo_empty_i;
    assign m_aw_valid_o = (state == WR_START) || (state == WR_ADDR);
    assign m_w_valid_o  = (state == WR_START) || (state == WR_DATA);
    assign m_b_ready_o  = (state == WR_WAIT_B);

    assign m_aw_o.addr = wr_addr;
    assign m_aw_o.prot = '0;
    assign m_w_o.data  = wr_data;
    assign m_w_o.strb  = '1;    // full word writes only

endmodule

`default_nettype wire

//--- axi_lite_reader.sv
`timescale 1ns/1ns
`default_nettype none

module axi_lite_reader (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        wr_done_i,
    input  wire                        fifo_full_i,
    output logic                       fifo_push_o,
    output usb_axi_pkg::word_t         fifo_word_o,
    output usb_axi_pkg::ar_chan_t      m_ar_o,
    output logic                       m_ar_valid_o,
    input  wire                        m_ar_ready_i,
    input  wire usb_axi_pkg::r_chan_t  m_r_i,
    input  wire                        m_r_valid_i,
    output logic                       m_r_ready_o
);

    import usb_axi_pkg::*;

    rd_state_e state;
    rd_state_e state_next;
    addr_t     rd_addr;
    xfer_cnt_t wr_cnt;    // completed writes
    xfer_cnt_t rd_cnt;    // completed reads
    logic      ar_fire;
    logic      r_fire;
    logic      r_okay;

    assign ar_fire = m_ar_valid_o && m_ar_ready_i;
    assign r_fire  = m_r_valid_i && m_r_ready_o;
    assign r_okay  = (m_r_i.resp == RESP_OKAY);

    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE:   if (rd_cnt != wr_cnt && !fifo_full_i) state_next = RD_ADDR;
            RD_ADDR:   if (ar_fire) state_next = RD_WAIT_R;
            RD_WAIT_R: if (r_fire) state_next = r_okay ? RD_IDLE : RD_ADDR;
            default:   state_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= RD_IDLE;
            rd_addr <= BASE_ADDR;
            wr_cnt  <= '0;
            rd_cnt  <= '0;
        end else begin
            state <= state_next;
            if (wr_done_i)
                wr_cnt <= wr_cnt + 1'b1;
            if (fifo_push_o) begin
                rd_cnt  <= rd_cnt + 1'b1;
                rd_addr <= rd_addr + ADDR_STEP;
            end
        end
    end

    // room was checked before ar and only one read is in flight
    assign fifo_push_o  = r_fire && r_okay;
    assign fifo_word_o  = m_r_i.data;
    assign m_ar_valid_o = (state == RD_ADDR);
    assign m_r_ready_o  = (state == RD_WAIT_R);
    assign m_ar_o.addr  = rd_addr;
    assign m_ar_o.prot  = '0;

endmodule

`default_nettype wire

//--- usb_axi_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module usb_axi_bridge (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    // FT232H bus
    input  wire                        usb_rxf_n_i,
    input  wire                        usb_txe_n_i,
    input  wire usb_axi_pkg::byte_t    usb_data_i,
    output logic                       usb_oe_n_o,
    output logic                       usb_rd_n_o,
    output logic                       usb_wr_n_o,
    output usb_axi_pkg::byte_t         usb_data_o,
    output logic                       usb_data_oe_o,
    // AXI4-Lite master
    output usb_axi_pkg::aw_chan_t      m_aw_o,
    output logic                       m_aw_valid_o,
    input  wire                        m_aw_ready_i,
    output usb_axi_pkg::w_chan_t       m_w_o,
    output logic                       m_w_valid_o,
    input  wire                        m_w_ready_i,
    input  wire usb_axi_pkg::b_chan_t  m_b_i,
    input  wire                        m_b_valid_i,
    output logic                       m_b_ready_o,
    output usb_axi_pkg::ar_chan_t      m_ar_o,
    output logic                       m_ar_valid_o,
    input  wire                        m_ar_ready_i,
    input  wire usb_axi_pkg::r_chan_t  m_r_i,
    input  wire                        m_r_valid_i,
    output logic                       m_r_ready_o
);

    import usb_axi_pkg::*;

    // host to memory
    logic  in_push;
    word_t in_word;
    logic  in_nearly_full;
    logic  in_pop;
    word_t in_head;
    logic  in_empty;
    // memory to host
    logic  out_push;
    word_t out_word;
    logic  out_full;
    logic  out_pop;
    word_t out_head;
    logic  out_empty;
    logic  wr_done;

    ft_fifo_port u_port (
        .sys_clk          (sys_clk),
        .sys_rst_n        (sys_rst_n),
        .usb_rxf_n_i      (usb_rxf_n_i),
        .usb_txe_n_i      (usb_txe_n_i),
        .usb_data_i       (usb_data_i),
        .usb_oe_n_o       (usb_oe_n_o),
        .usb_rd_n_o       (usb_rd_n_o),
        .usb_wr_n_o       (usb_wr_n_o),
        .usb_data_o       (usb_data_o),
        .usb_data_oe_o    (usb_data_oe_o),
        .in_push_o        (in_push),
        .in_word_o        (in_word),
        .in_nearly_full_i (in_nearly_full),
        .out_pop_o        (out_pop),
        .out_word_i       (out_head),
        .out_empty_i      (out_empty)
    );

    word_fifo u_in_fifo (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .push_i        (in_push),
        .push_word_i   (in_word),
        .pop_i         (in_pop),
        .pop_word_o    (in_head),
        .empty_o       (in_empty),
        .full_o        (),
        .nearly_full_o (in_nearly_full)
    );

    word_fifo u_out_fifo (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .push_i        (out_push),
        .push_word_i   (out_word),
        .pop_i         (out_pop),
        .pop_word_o    (out_head),
        .empty_o       (out_empty),
        .full_o        (out_full),
        .nearly_full_o ()
    );

    axi_lite_writer u_writer (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .fifo_empty_i (in_empty),
        .fifo_word_i  (in_head),
        .fifo_pop_o   (in_pop),
        .m_aw_o       (m_aw_o),
        .m_aw_valid_o (m_aw_valid_o),
        .m_aw_ready_i (m_aw_ready_i),
        .m_w_o        (m_w_o),
        .m_w_valid_o  (m_w_valid_o),
        .m_w_ready_i  (m_w_ready_i),
        .m_b_i        (m_b_i),
        .m_b_valid_i  (m_b_valid_i),
        .m_b_ready_o  (m_b_ready_o),
        .wr_done_o    (wr_done)
    );

    axi_lite_reader u_reader (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .wr_done_i    (wr_done),
        .fifo_full_i  (out_full),
        .fifo_push_o  (out_push),
        .fifo_word_o  (out_word),
        .m_ar_o       (m_ar_o),
        .m_ar_valid_o (m_ar_valid_o),
        .m_ar_ready_i (m_ar_ready_i),
        .m_r_i        (m_r_i),
        .m_r_valid_i  (m_r_valid_i),
        .m_r_ready_o  (m_r_ready_o)
    );

endmodule

`default_nettype wire

//--- tb_usb_axi_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_usb_axi_bridge;

    import usb_axi_pkg::*;

    localparam int WORDS_TOTAL = 40;    // 8 plain and 32 stalled
    localparam int CYCLE_LIMIT = 400 * WORDS_TOTAL + 200;

    logic     sys_clk;
    logic     sys_rst_n;
    logic     usb_rxf_n_i;
    logic     usb_txe_n_i;
    byte_t    usb_data_i;
    logic     usb_oe_n_o;
    logic     usb_rd_n_o;
    logic     usb_wr_n_o;
    byte_t    usb_data_o;
    logic     usb_data_oe_o;
    aw_chan_t m_aw_o;
    logic     m_aw_valid_o;
    logic     m_aw_ready_i;
    w_chan_t  m_w_o;
    logic     m_w_valid_o;
    logic     m_w_ready_i;
    b_chan_t  m_b_i;
    logic     m_b_valid_i;
    logic     m_b_ready_o;
    ar_chan_t m_ar_o;
    logic     m_ar_valid_o;
    logic     m_ar_ready_i;
    r_chan_t  m_r_i;
    logic     m_r_valid_i;
    logic     m_r_ready_o;

    integer seed = 32'hb4075974;
    int     errors;
    int     checks;
    int     cycles;
    int     echo_cnt;
    int     writes_done;
    int     reads_done;
    int     reads_issued;
    bit     active;
    bit     stall_mode;

    byte_t  host_q[$];    // bytes still to hand to the DUT
    byte_t  exp_q[$];     // bytes still to come back
    byte_t  sent[$];      // every byte sent, by index
    word_t  mem [addr_t];
    bit     done_addr [addr_t];

    // memory model state
    bit     aw_got;
    bit     w_got;
    bit     b_vld;
    bit     r_vld;
    bit     r_pend;
    int     r_wait;
    addr_t  aw_addr_q;
    addr_t  b_addr;
    word_t  w_data_q;
    word_t  r_word;

    usb_axi_bridge i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    //****************************************
    // reference and compare tasks
    //****************************************
    function automatic word_t expected_word(input byte_t b0, input byte_t b1,
                                            input byte_t b2, input byte_t b3);
        return {b3, b2, b1, b0};    // lsb first
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    //****************************************
    // FT232H host model
    //****************************************
    always @(posedge sys_clk) begin
        if (sys_rst_n && !usb_rd_n_o && !usb_rxf_n_i) begin
            host_q.delete(0);    // byte taken so the next one is up
            checks++;
            if (usb_oe_n_o !== 1'b0 || usb_data_oe_o !== 1'b0) begin
                $display("error at %0t ns: byte read with oe_n %b and data_oe %b",
                         $time, usb_oe_n_o, usb_data_oe_o);
                errors++;
            end
        end
        if (host_q.size() > 0 && !(stall_mode && (($random(seed) & 3) == 0))) begin
            usb_rxf_n_i <= 1'b0;
            usb_data_i  <= host_q[0];
        end else begin
            usb_rxf_n_i <= 1'b1;
        end
    end

    // echo side compares against the sent stream
    always @(posedge sys_clk) begin
        if (sys_rst_n && !usb_wr_n_o) begin
            checks++;
            if (usb_data_oe_o !== 1'b1) begin
                $display("error at %0t ns: data_oe is %b while a byte is written",
                         $time, usb_data_oe_o);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("echoed byte %h arrived with no byte left to expect", usb_data_o);
                errors++;
            end else begin
                check_byte(usb_data_o, exp_q.pop_front(), "echoed byte");
            end
            echo_cnt++;
        end
        usb_txe_n_i <= !active || (stall_mode && (($random(seed) & 1) == 0));
    end

    //****************************************
    // AXI4-Lite memory model
    //****************************************
    always @(posedge sys_clk) begin
        int idx;
        if (sys_rst_n) begin
            if (b_vld && m_b_ready_o) begin
                b_vld = 1'b0;
                done_addr[b_addr] = 1'b1;
                writes_done++;
            end
            if (m_aw_valid_o && m_aw_ready_i) begin
                check_addr(m_aw_o.addr, BASE_ADDR + ADDR_STEP * addr_t'(writes_done),
                           "write address");
                checks++;
                if (m_aw_o.prot !== 3'b000) begin
                    $display("error at %0t ns: write prot is %b, expected 000",
                             $time, m_aw_o.prot);
                    errors++;
                end
                aw_addr_q = m_aw_o.addr;
                aw_got    = 1'b1;
            end
            if (m_w_valid_o && m_w_ready_i) begin
                idx = 4 * writes_done;
                if (idx + 3 < sent.size()) begin
                    check_word(m_w_o.data, expected_word(sent[idx], sent[idx+1],
                               sent[idx+2], sent[idx+3]), "write data");
                end else begin
                    $display("write data %h seen before its bytes were sent", m_w_o.data);
                    errors++;
                end
                checks++;
                if (m_w_o.strb !== 4'b1111) begin
                    $display("error at %0t ns: write strobes are %b, expected 1111",
                             $time, m_w_o.strb);
                    errors++;
                end
                w_data_q = m_w_o.data;
                w_got    = 1'b1;
            end
            if (aw_got && w_got) begin
                mem[aw_addr_q] = w_data_q;
                b_addr = aw_addr_q;
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_vld  = 1'b1;
            end

            if (r_vld && m_r_ready_o) begin
                r_vld  = 1'b0;
                r_pend = 1'b0;
                reads_done++;
            end
            if (m_ar_valid_o && m_ar_ready_i) begin
                if (reads_issued >= writes_done) begin
                    $display("read at %h issued ahead of the completed writes", m_ar_o.addr);
                    errors++;
                end
                if (!done_addr.exists(m_ar_o.addr)) begin
                    $display("read at %h from an address not yet written", m_ar_o.addr);
                    errors++;
                end
                check_addr(m_ar_o.addr, BASE_ADDR + ADDR_STEP * addr_t'(reads_issued),
                           "read address");
                checks++;
                if (m_ar_o.prot !== 3'b000) begin
                    $display("error at %0t ns: read prot is %b, expected 000",
                             $time, m_ar_o.prot);
                    errors++;
                end
                r_word = mem.exists(m_ar_o.addr) ? mem[m_ar_o.addr] : '0;
                r_pend = 1'b1;
                r_wait = stall_mode ? ($random(seed) & 7) : 0;
                reads_issued++;
            end else if (r_pend && !r_vld) begin
                if (r_wait == 0)
                    r_vld = 1'b1;
                else
                    r_wait--;
            end
        end
        m_b_valid_i  <= b_vld;
        m_b_i.resp   <= RESP_OKAY;
        m_r_valid_i  <= r_vld;
        m_r_i.data   <= r_word;
        m_r_i.resp   <= RESP_OKAY;
        m_aw_ready_i <= active && (!stall_mode || (($random(seed) & 1) == 1));
        m_w_ready_i  <= active && (!stall_mode || (($random(seed) & 1) == 1));
        m_ar_ready_i <= active && (!stall_mode || (($random(seed) & 1) == 1));
    end

    // run limit
    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the echo did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    //****************************************
    // tests
    //****************************************
    task automatic run_echo(input int n_words, input bit stall, input string name);
        int    err0;
        int    target;
        byte_t b;
        err0 = errors;
        @(negedge sys_clk);
        stall_mode = stall;
        active     = 1'b1;
        for (int i = 0; i < 4 * n_words; i++) begin
            b = byte_t'($random(seed));
            host_q.push_back(b);
            exp_q.push_back(b);
            sent.push_back(b);
        end
        target = echo_cnt + 4 * n_words;
        while (echo_cnt < target)
            @(negedge sys_clk);
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = errors;
        @(negedge sys_clk);
        checks++;
        if (usb_oe_n_o !== 1'b1 || usb_rd_n_o !== 1'b1 || usb_wr_n_o !== 1'b1 ||
            usb_data_oe_o !== 1'b0) begin
            $display("after reset a FT232H strobe or output enable is not idle");
            errors++;
        end
        checks++;
        if (m_aw_valid_o !== 1'b0 || m_w_valid_o !== 1'b0 || m_ar_valid_o !== 1'b0 ||
            m_b_ready_o !== 1'b0 || m_r_ready_o !== 1'b0) begin
            $display("after reset an AXI valid or ready output is not low");
            errors++;
        end
        $display("test reset values: %0d errors", errors - err0);
    endtask

    initial begin
        sys_rst_n    = 1'b0;
        usb_rxf_n_i  = 1'b1;
        usb_txe_n_i  = 1'b1;
        usb_data_i   = '0;
        m_aw_ready_i = 1'b0;
        m_w_ready_i  = 1'b0;
        m_b_i        = '0;
        m_b_valid_i  = 1'b0;
        m_ar_ready_i = 1'b0;
        m_r_i        = '0;
        m_r_valid_i  = 1'b0;
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        check_reset_state();
        run_echo(8, 1'b0, "echo of 8 words, no stalls");
        run_echo(32, 1'b1, "echo of 32 words, random stalls");

        checks++;
        if (writes_done != WORDS_TOTAL || reads_done != WORDS_TOTAL) begin
            $display("%0d writes and %0d reads completed for %0d words",
                     writes_done, reads_done, WORDS_TOTAL);
            errors++;
        end
        $display("checks %0d, errors %0d, bytes echoed %0d", checks, errors, echo_cnt);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_axi_bridge.f
usb_axi_pkg.sv
word_fifo.sv
ft_fifo_port.sv
axi_lite_writer.sv
axi_lite_reader.sv
usb_axi_bridge.sv
tb_usb_axi_bridge.sv
